/* compile.f */
rtl/scratch_pkg.sv
rtl/dual_port_mem.sv
rtl/wb_port_ctrl.sv
rtl/scratchpad_top.sv
test/scratchpad_tb.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := scratchpad_tb
FILELIST := compile.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := Testbench failed
PASS_MSG := Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/scratchpad_tb.sv */
// self-checking testbench for the two-port scratchpad, top module of the simulation build
`timescale 1ns/1ps

module scratchpad_tb
    import scratch_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 4000;    // about three times the length of the tests

    logic     clk;
    logic     rst;
    logic     cyc_a, stb_a, we_a, ack_a;
    logic     cyc_b, stb_b, we_b, ack_b;
    wb_addr_t adr_a, adr_b;
    data_t    dat_w_a, dat_r_a;
    data_t    dat_w_b, dat_r_b;

    data_t       model_mem [256];    // reference copy of the array
    data_t       sub_a_model;
    data_t       sub_b_model;
    logic        chk_a, chk_b;       // current access is a read to compare
    data_t       exp_a, exp_b;
    string       test_name;
    logic [31:0] lcg_state;
    int          cycles = 0;
    mem_addr_t   list_a [32];
    mem_addr_t   list_b [32];

    scratchpad_top dut (
        .clk (clk), .rst (rst),
        .cyc_a (cyc_a), .stb_a (stb_a), .we_a (we_a), .adr_a (adr_a),
        .dat_w_a (dat_w_a), .dat_r_a (dat_r_a), .ack_a (ack_a),
        .cyc_b (cyc_b), .stb_b (stb_b), .we_b (we_b), .adr_b (adr_b),
        .dat_w_b (dat_w_b), .dat_r_b (dat_r_b), .ack_b (ack_b)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic data_t rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    // memory half returns the byte, difference half the byte minus the subtrahend
    function automatic data_t expected_read(input wb_addr_t adr, input data_t sub);
        if (adr[WB_ADDR_W-1]) begin
            return model_mem[adr[MEM_ADDR_W-1:0]] - sub;
        end
        return model_mem[adr[MEM_ADDR_W-1:0]];
    endfunction

    task automatic access_a(input logic wr, input wb_addr_t adr, input data_t wdata,
                            input data_t expect_val);
        @(negedge clk);
        exp_a   = expect_val;
        chk_a   = !wr;
        we_a    = wr;
        adr_a   = adr;
        dat_w_a = wdata;
        cyc_a   = 1'b1;
        stb_a   = 1'b1;
        @(negedge clk);
        while (!ack_a) begin
            @(negedge clk);
        end
        @(negedge clk);    // ack taken at the edge just passed
        cyc_a = 1'b0;
        stb_a = 1'b0;
        chk_a = 1'b0;
        if (wr && adr[WB_ADDR_W-1]) begin
            sub_a_model = wdata;
        end else if (wr) begin
            model_mem[adr[MEM_ADDR_W-1:0]] = wdata;
        end
    endtask

    task automatic access_b(input logic wr, input wb_addr_t adr, input data_t wdata,
                            input data_t expect_val);
        @(negedge clk);
        exp_b   = expect_val;
        chk_b   = !wr;
        we_b    = wr;
        adr_b   = adr;
        dat_w_b = wdata;
        cyc_b   = 1'b1;
        stb_b   = 1'b1;
        @(negedge clk);
        while (!ack_b) begin
            @(negedge clk);
        end
        @(negedge clk);
        cyc_b = 1'b0;
        stb_b = 1'b0;
        chk_b = 1'b0;
        if (wr && adr[WB_ADDR_W-1]) begin
            sub_b_model = wdata;
        end else if (wr) begin
            model_mem[adr[MEM_ADDR_W-1:0]] = wdata;
        end
    endtask

    task automatic write_a(input wb_addr_t adr, input data_t d);
        access_a(1'b1, adr, d, '0);
    endtask

    task automatic write_b(input wb_addr_t adr, input data_t d);
        access_b(1'b1, adr, d, '0);
    endtask

    task automatic read_a(input wb_addr_t adr);
        access_a(1'b0, adr, '0, expected_read(adr, sub_a_model));    // expected taken up front
    endtask

    task automatic read_b(input wb_addr_t adr);
        access_b(1'b0, adr, '0, expected_read(adr, sub_b_model));
    endtask

    read_a_value: assert property (
        @(posedge clk) disable iff (rst) (ack_a && chk_a) |-> dat_r_a == exp_a
    ) else begin
        $display("ERR %s port a expected %h actual %h",
                 test_name, $sampled(exp_a), $sampled(dat_r_a));
        abort_run();
    end

    read_b_value: assert property (
        @(posedge clk) disable iff (rst) (ack_b && chk_b) |-> dat_r_b == exp_b
    ) else begin
        $display("ERR %s port b expected %h actual %h",
                 test_name, $sampled(exp_b), $sampled(dat_r_b));
        abort_run();
    end

    // ack exactly two edges after stb is first seen, one cycle long
    ack_a_timing: assert property (
        @(posedge clk) disable iff (rst)
        ack_a == ($past(cyc_a && stb_a, 2) && !$past(stb_a, 3))
    ) else begin
        $display("port a ack out of step with its strobe in test %s", test_name);
        abort_run();
    end

    ack_b_timing: assert property (
        @(posedge clk) disable iff (rst)
        ack_b == ($past(cyc_b && stb_b, 2) && !$past(stb_b, 3))
    ) else begin
        $display("port b ack out of step with its strobe in test %s", test_name);
        abort_run();
    end

    ack_quiet_in_reset: assert property (
        @(posedge clk) rst |-> !ack_a && !ack_b
    ) else begin
        $display("an ack was raised while reset was held");
        abort_run();
    end

    initial begin
        int        i;
        mem_addr_t aa;
        data_t     da;
        data_t     db;

        clk = 1'b0;
        rst = 1'b1;
        {cyc_a, stb_a, we_a, cyc_b, stb_b, we_b} = '0;
        adr_a = '0;
        adr_b = '0;
        dat_w_a = '0;
        dat_w_b = '0;
        {chk_a, chk_b, exp_a, exp_b} = '0;
        sub_a_model = '0;    // subtrahends start at zero
        sub_b_model = '0;
        lcg_state = 32'hca6;
        test_name = "reset";
        repeat (16) @(negedge clk);
        rst = 1'b0;
        repeat (6) @(negedge clk);    // idle, no ack expected

        test_name = "basic";
        for (i = 0; i < 32; i++) begin
            list_a[i] = rand_byte();
            write_a({1'b0, list_a[i]}, rand_byte());
        end
        for (i = 0; i < 32; i++) read_b({1'b0, list_a[i]});
        for (i = 0; i < 32; i++) begin
            list_b[i] = rand_byte();
            write_b({1'b0, list_b[i]}, rand_byte());
        end
        for (i = 0; i < 32; i++) read_a({1'b0, list_b[i]});

        test_name = "diff_reset_zero";
        write_a(9'h040, 8'h10);
        read_a(9'h140);
        read_b(9'h140);
        test_name = "diff_wrap";
        write_a(9'h100, 8'hf0);    // larger than the byte
        read_a(9'h140);
        read_b(9'h140);            // port b still at zero
        write_b(9'h1ff, 8'h03);
        read_b(9'h140);
        read_a(9'h140);
        test_name = "diff_random";
        for (i = 0; i < 8; i++) begin
            aa = rand_byte();
            write_b({1'b0, aa}, rand_byte());
            write_a({1'b1, rand_byte()}, rand_byte());
            write_b({1'b1, rand_byte()}, rand_byte());
            read_a({1'b1, aa});
            read_b({1'b1, aa});
        end

        test_name = "parallel";
        for (i = 0; i < 32; i++) begin
            list_a[i] = rand_byte();
            list_b[i] = rand_byte();
            if (list_b[i] == list_a[i]) list_b[i] = list_a[i] + 8'd1;
            da = rand_byte();
            db = rand_byte();
            fork
                write_a({1'b0, list_a[i]}, da);
                write_b({1'b0, list_b[i]}, db);
            join
        end
        for (i = 0; i < 32; i++) begin
            fork
                read_a({1'b0, list_b[i]});
                read_b({1'b0, list_a[i]});
            join
        end

        test_name = "collision";
        for (i = 0; i < 8; i++) begin
            aa = rand_byte();
            da = rand_byte();
            db = ~da;
            fork
                write_a({1'b0, aa}, da);
                write_b({1'b0, aa}, db);
            join
            model_mem[aa] = da;    // b first, then a on the shared edge
            read_b({1'b0, aa});
        end

        test_name = "read_first";
        for (i = 0; i < 8; i++) begin
            aa = rand_byte();
            write_a({1'b0, aa}, rand_byte());
            da = rand_byte();
            fork
                write_a({1'b0, aa}, da);
                read_b({1'b0, aa});    // old byte expected
            join
            read_b({1'b0, aa});
        end

        test_name = "held_stb";
        @(negedge clk);
        exp_a = expected_read(9'h040, sub_a_model);
        chk_a = 1'b1;
        we_a  = 1'b0;
        adr_a = 9'h040;
        cyc_a = 1'b1;
        stb_a = 1'b1;
        repeat (10) @(negedge clk);    // one ack, then a quiet hold
        cyc_a = 1'b0;
        stb_a = 1'b0;
        chk_a = 1'b0;

        test_name = "done";
        repeat (4) @(negedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule : scratchpad_tb

/* rtl/scratchpad_top.sv */
// scratchpad top level: two Wishbone classic ports sharing one dual-port byte memory
`timescale 1ns/1ps

module scratchpad_top
    import scratch_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // port a
    input  logic     cyc_a,
    input  logic     stb_a,
    input  logic     we_a,
    input  wb_addr_t adr_a,
    input  data_t    dat_w_a,
    output data_t    dat_r_a,
    output logic     ack_a,

    // port b
    input  logic     cyc_b,
    input  logic     stb_b,
    input  logic     we_b,
    input  wb_addr_t adr_b,
    input  data_t    dat_w_b,
    output data_t    dat_r_b,
    output logic     ack_b
);

    logic      mem_en_a, mem_we_a;
    logic      mem_en_b, mem_we_b;
    mem_addr_t mem_addr_a, mem_addr_b;
    data_t     mem_wdata_a, mem_wdata_b;
    data_t     mem_rdata_a, mem_rdata_b;

    wb_port_ctrl port_a (
        .clk       (clk),
        .rst       (rst),
        .cyc       (cyc_a),
        .stb       (stb_a),
        .we        (we_a),
        .adr       (adr_a),
        .dat_w     (dat_w_a),
        .dat_r     (dat_r_a),
        .ack       (ack_a),
        .mem_en    (mem_en_a),
        .mem_we    (mem_we_a),
        .mem_addr  (mem_addr_a),
        .mem_wdata (mem_wdata_a),
        .mem_rdata (mem_rdata_a)
    );

    wb_port_ctrl port_b (
        .clk       (clk),
        .rst       (rst),
        .cyc       (cyc_b),
        .stb       (stb_b),
        .we        (we_b),
        .adr       (adr_b),
        .dat_w     (dat_w_b),
        .dat_r     (dat_r_b),
        .ack       (ack_b),
        .mem_en    (mem_en_b),
        .mem_we    (mem_we_b),
        .mem_addr  (mem_addr_b),
        .mem_wdata (mem_wdata_b),
        .mem_rdata (mem_rdata_b)
    );

    dual_port_mem mem (
        .clk     (clk),
        .en_a    (mem_en_a),
        .we_a    (mem_we_a),
        .en_b    (mem_en_b),
        .we_b    (mem_we_b),
        .addr_a  (mem_addr_a),
        .addr_b  (mem_addr_b),
        .wdata_a (mem_wdata_a),
        .wdata_b (mem_wdata_b),
        .rdata_a (mem_rdata_a),
        .rdata_b (mem_rdata_b)
    );

endmodule : scratchpad_top

/* rtl/wb_port_ctrl.sv */
// Wishbone classic slave for one scratchpad port that the top level instances twice
`timescale 1ns/1ps

module wb_port_ctrl
    import scratch_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // Wishbone classic slave side
    input  logic      cyc,
    input  logic      stb,
    input  logic      we,
    input  wb_addr_t  adr,
    input  data_t     dat_w,
    output data_t     dat_r,
    output logic      ack,

    // shared memory port
    output logic      mem_en,
    output logic      mem_we,
    output mem_addr_t mem_addr,
    output data_t     mem_wdata,
    input  data_t     mem_rdata
);

    port_state_t state;
    port_state_t state_next;

    logic      stb_q;      // stb at the previous edge
    logic      win_q;      // 1 = difference half
    logic      we_q;       // latched write flag
    mem_addr_t addr_q;     // latched word address
    data_t     wdata_q;    // latched write data
    data_t     sub_q;      // port subtrahend

    logic      req;
    logic      sub_load;
    data_t     diff;

    assign req = cyc && stb && !stb_q;    // only a rising strobe starts a request

    // subtrahend is written in ACCESS, at the same edge a memory write would land
    assign sub_load = (state == ACCESS) && we_q && win_q;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (req) begin
                    state_next = ACCESS;
                end
            end
            ACCESS: begin
                state_next = RESPOND;    // single-cycle access
            end
            RESPOND: begin
                state_next = IDLE;       // held stb must drop first
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            stb_q <= 1'b0;
            win_q <= 1'b0;
            we_q  <= 1'b0;
        end else begin
            state <= state_next;
            stb_q <= stb;
            if (state == IDLE && req) begin
                win_q <= adr[WB_ADDR_W-1];
                we_q  <= we;
            end
        end
    end

    // address and data of the request
    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            addr_q  <= adr[MEM_ADDR_W-1:0];
            wdata_q <= dat_w;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sub_q <= '0;
        end else if (sub_load) begin
            sub_q <= wdata_q;
        end
    end

    // Memory is only enabled in ACCESS. A subtrahend write leaves the array
    // alone and every other request reads or writes the latched word.
    assign mem_en    = (state == ACCESS) && !(we_q && win_q);
    assign mem_we    = (state == ACCESS) && we_q && !win_q;
    assign mem_addr  = addr_q;
    assign mem_wdata = wdata_q;

    assign diff = mem_rdata - sub_q;    // wraps modulo 256

    assign ack = (state == RESPOND);

    always_comb begin
        dat_r = '0;
        if (state == RESPOND && !we_q) begin
            dat_r = win_q ? diff : mem_rdata;
        end
    end

    // one ack per request, never back to back
    ack_single: assert property (
        @(posedge clk) disable iff (rst) ack |=> !ack
    ) else $error("ack held for two cycles");

    // the master keeps cyc open until it takes the ack
    ack_has_cyc: assert property (
        @(posedge clk) disable iff (rst) ack |-> cyc
    ) else $error("ack given after the master dropped cyc");

endmodule : wb_port_ctrl

/* rtl/dual_port_mem.sv */
// shared 256 x 8 synchronous RAM with two read-first ports, used by the scratchpad top level
`timescale 1ns/1ps

module dual_port_mem
    import scratch_pkg::*;
(
    input  logic      clk,
    input  logic      en_a,
    input  logic      we_a,
    input  logic      en_b,
    input  logic      we_b,
    input  mem_addr_t addr_a,
    input  mem_addr_t addr_b,
    input  data_t     wdata_a,
    input  data_t     wdata_b,
    output data_t     rdata_a,
    output data_t     rdata_b
);

    localparam int DEPTH = 1 << MEM_ADDR_W;

    data_t mem_array [DEPTH];    // contents are not cleared

    // Both ports share one clocked block. Reads take the value from before the
    // edge, so a read that meets a write on the other port returns the old byte.
    // The port b write is listed first; on a same-address collision the later
    // port a assignment is the one that lands.
    always_ff @(posedge clk) begin
        if (en_b) begin
            rdata_b <= mem_array[addr_b];    // read-first
            if (we_b) begin
                mem_array[addr_b] <= wdata_b;
            end
        end
        if (en_a) begin
            rdata_a <= mem_array[addr_a];    // read-first
            if (we_a) begin
                mem_array[addr_a] <= wdata_a;    // port a wins collisions
            end
        end
    end

    // an enabled port must present a resolved address
    addr_a_known: assert property (
        @(posedge clk) en_a |-> !$isunknown(addr_a)
    ) else $error("port a enabled with unknown address");

    addr_b_known: assert property (
        @(posedge clk) en_b |-> !$isunknown(addr_b)
    ) else $error("port b enabled with unknown address");

    // write strobe without enable would be dropped silently
    we_a_needs_en: assert property (
        @(posedge clk) we_a |-> en_a
    ) else $error("port a write without enable");

    we_b_needs_en: assert property (
        @(posedge clk) we_b |-> en_b
    ) else $error("port b write without enable");

endmodule : dual_port_mem

/* rtl/scratch_pkg.sv */
// shared widths, vector types and port FSM states, imported by every scratchpad module
package scratch_pkg;

    localparam int DATA_W     = 8;     // byte wide data bus
    localparam int MEM_ADDR_W = 8;     // 256 memory words
    localparam int WB_ADDR_W  = 9;     // top bit picks the difference half

    // stored bytes, bus data and subtrahend
    typedef logic [DATA_W-1:0] data_t;

    // word address into the shared array
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    // full bus address, window bit on top
    typedef logic [WB_ADDR_W-1:0] wb_addr_t;

    // one request in flight per port
    typedef enum logic [1:0] {
        IDLE    = 2'd0,    // waiting for stb
        ACCESS  = 2'd1,    // memory port driven
        RESPOND = 2'd2     // ack high, dat_r valid
    } port_state_t;

endpackage : scratch_pkg
